// ==== arcade_io.f ====
arcade_io_pkg.sv
ps2_key_decoder.sv
joy_debounce.sv
control_mapper.sv
video_expander.sv
sigma_delta_dac.sv
arcade_io_top.sv
arcade_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the arcade_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module arcade_io_tb -f arcade_io.f

output=$(./obj_dir/Varcade_io_tb)
echo "$output"

if echo "$output" | grep -q "STATUS: PASS"; then
	exit 0
fi
exit 1

// ==== arcade_io_tb.sv ====
//========================================
// Testbench for the arcade host glue
// Clock, reset, stimulus, reference models, checking assertions
//========================================
`timescale 1ns/10ps

module arcade_io_tb import arcade_io_pkg::*; ();

	localparam int DEBOUNCE_CYCLES = 4;
	localparam int PIX_DIV         = 4;
	localparam int MAX_CYCLES      = 6000;

	logic          clk_sys;
	logic          rst_n;
	scan_code_t    scan_code;
	logic          scan_valid;
	logic          scan_ready;
	joy_t          joy_0;
	joy_t          joy_1;
	logic          rotate;
	game_in_t      game_in0;
	game_in_t      game_in1;
	colour3_t      r_in;
	colour3_t      g_in;
	colour2_t      b_in;
	logic          hs;
	logic          vs;
	logic          hblank;
	logic          vblank;
	logic          pix_ce;
	vga_colour_t   vga_r;
	vga_colour_t   vga_g;
	vga_colour_t   vga_b;
	logic          vga_hs;
	logic          vga_vs;
	audio_sample_t sample;
	logic          audio_l;
	logic          audio_r;

	int       value_errors;
	int       other_errors;
	int       cycles;
	int       run_cycles;
	key_vec_t m_keys;
	logic     m_ext;
	logic     m_rel;

	// Byte pool for random key traffic, the last two are not in the key table
	scan_code_t code_pool [12] = '{KEY_RELEASE_PREFIX, KEY_EXTENDED_PREFIX, SC_SPACE, SC_1,
		SC_2, SC_5, SC_RIGHT, SC_LEFT, SC_UP, SC_DOWN, 8'h1C, 8'h5A};

	arcade_io_top #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.PIX_DIV         (PIX_DIV)
	) arcade_io_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ========================================
	// Concurrent checks
	// ========================================
	a_audio_mono: assert property (@(posedge clk_sys) audio_r == audio_l)
		else begin
			other_errors++;
			$display("Right audio channel differs from the left channel");
		end

	a_ce_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pix_ce |-> ##PIX_DIV pix_ce)
		else begin
			other_errors++;
			$display("Pixel enable did not return after %0d cycles", PIX_DIV);
		end

	// Hard stop in case a wait loop never ends
	always @(posedge clk_sys) begin
		cycles++;
		if (rst_n) run_cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ========================================
	// Reference models and helpers
	// ========================================
	// First game byte from the merge, orientation and packing rules
	function automatic game_in_t expect_in0(key_vec_t k, joy_t j0, joy_t j1, logic rot);
		logic u, d, l, r, f;
		logic eu, ed, el, er;
		u = k[KEY_UP] | j0[JOY_UP] | j1[JOY_UP];
		d = k[KEY_DOWN] | j0[JOY_DOWN] | j1[JOY_DOWN];
		l = k[KEY_LEFT] | j0[JOY_LEFT] | j1[JOY_LEFT];
		r = k[KEY_RIGHT] | j0[JOY_RIGHT] | j1[JOY_RIGHT];
		f = k[KEY_FIRE] | j0[JOY_FIRE] | j1[JOY_FIRE];
		{eu, ed, el, er} = rot ? {r, l, u, d} : {u, d, l, r};
		return ~{2'b00, k[KEY_COIN], f, ed, er, el, eu};
	endfunction

	// Second game byte, only the two start keys pull their lines low
	function automatic game_in_t expect_in1(key_vec_t k);
		game_in_t e;
		e    = '1;
		e[6] = !k[KEY_START2];
		e[5] = !k[KEY_START1];
		return e;
	endfunction

	// Key model fed by the package table
	task automatic model_byte(scan_code_t code);
		int   idx;
		logic ext;
		idx = -1;
		ext = 1'b0;
		if (code == KEY_RELEASE_PREFIX) m_rel = 1'b1;
		else if (code == KEY_EXTENDED_PREFIX) m_ext = 1'b1;
		else begin
			case (code)
				SC_SPACE: idx = KEY_FIRE;
				SC_1:     idx = KEY_START1;
				SC_2:     idx = KEY_START2;
				SC_5:     idx = KEY_COIN;
				SC_RIGHT: {idx, ext} = {32'(KEY_RIGHT), 1'b1};
				SC_LEFT:  {idx, ext} = {32'(KEY_LEFT), 1'b1};
				SC_UP:    {idx, ext} = {32'(KEY_UP), 1'b1};
				SC_DOWN:  {idx, ext} = {32'(KEY_DOWN), 1'b1};
				default:  idx = -1;
			endcase
			if (idx >= 0 && ext == m_ext) m_keys[idx] = !m_rel;
			m_ext = 1'b0;
			m_rel = 1'b0;
		end
	endtask

	task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
		assert (exp == act)
			else begin
				value_errors++;
				$display("Fail %s: expected %h, actual %h", name, exp, act);
			end
	endtask

	// One byte through the valid/ready handshake, checked two cycles later
	task automatic send_byte(scan_code_t code, int gap);
		int tries;
		tries = 0;
		@(negedge clk_sys);
		while (!scan_ready && tries < 10) begin
			tries++;
			@(negedge clk_sys);
		end
		if (!scan_ready) begin
			other_errors++;
			$display("Decoder never became ready for a scancode");
		end
		scan_code  = code;
		scan_valid = 1'b1;
		@(negedge clk_sys);
		scan_valid = 1'b0;
		scan_code  = scan_code_t'($urandom);
		model_byte(code);
		@(negedge clk_sys);
		compare_value("key byte 0", expect_in0(m_keys, joy_0, joy_1, rotate), game_in0);
		compare_value("key byte 1", expect_in1(m_keys), game_in1);
		repeat (gap) @(negedge clk_sys);
	endtask

	task automatic release_all();
		// An unknown byte first drops any prefix left over from earlier traffic
		send_byte(code_pool[10], 0);
		for (int i = 2; i < 6; i++) begin
			send_byte(KEY_RELEASE_PREFIX, 0);
			send_byte(code_pool[i], 0);
		end
		for (int i = 6; i < 10; i++) begin
			send_byte(KEY_EXTENDED_PREFIX, 0);
			send_byte(KEY_RELEASE_PREFIX, 0);
			send_byte(code_pool[i], 0);
		end
		compare_value("keys released", 0, m_keys);
	endtask

	// Poll the first game byte until it reaches the value or the limit runs out
	task automatic wait_for_in0(string name, game_in_t exp, int limit);
		int n;
		n = 0;
		while (game_in0 != exp && n < limit) begin
			n++;
			@(negedge clk_sys);
		end
		if (game_in0 != exp) begin
			other_errors++;
			$display("%s: game byte 0 did not reach %h within %0d cycles", name, exp, limit);
		end
	endtask

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		logic [19:0] exp_vid;
		logic        ce_seen;
		int          ce_count;
		int          ones;
		audio_sample_t levels [4];
		void'($urandom(6981));
		{scan_code, scan_valid, joy_0, joy_1, rotate} = '0;
		{r_in, g_in, b_in, hs, vs, hblank, vblank, sample} = '0;
		{value_errors, other_errors, cycles, run_cycles} = '0;
		{m_keys, m_ext, m_rel} = '0;
		rst_n = 1'b0;
		repeat (3) @(negedge clk_sys);
		compare_value("reset ready", 0, scan_ready);
		compare_value("reset game bytes", 16'hFFFF, {game_in0, game_in1});
		compare_value("reset colour", 0, {vga_r, vga_g, vga_b});
		compare_value("reset outputs", 0, {vga_hs, vga_vs, audio_l, audio_r, pix_ce});
		rst_n = 1'b1;
		@(negedge clk_sys);
		compare_value("ready after reset", 1, scan_ready);
		compare_value("game bytes after reset", 16'hFFFF, {game_in0, game_in1});
		compare_value("colour after reset", 0, {vga_r, vga_g, vga_b, vga_hs, vga_vs});
		compare_value("audio and enable after reset", 0, {audio_l, audio_r, pix_ce});

		// Random key traffic
		for (int i = 0; i < 80; i++) begin
			send_byte(code_pool[$urandom % 12], $urandom % 3);
		end
		release_all();

		// Short glitches on fire never pass the debouncer
		for (int len = 1; len < DEBOUNCE_CYCLES; len++) begin
			for (int i = 0; i < len + DEBOUNCE_CYCLES + 3; i++) begin
				@(negedge clk_sys);
				joy_0[JOY_FIRE] = (i < len);
				compare_value("joystick glitch", 8'hFF, game_in0);
			end
		end
		joy_0 = 8'h11;
		wait_for_in0("joystick hold", expect_in0(m_keys, joy_0, joy_1, 1'b0), DEBOUNCE_CYCLES + 2);
		send_byte(SC_5, 0);
		send_byte(KEY_EXTENDED_PREFIX, 0);
		send_byte(SC_UP, 2);
		joy_0 = '0;
		repeat (DEBOUNCE_CYCLES + 3) @(negedge clk_sys);
		release_all();

		// Orientation with a held key down on top of every stick direction
		send_byte(KEY_EXTENDED_PREFIX, 0);
		send_byte(SC_DOWN, 0);
		for (int c = 0; c < 16; c++) begin
			joy_1  = joy_t'(c);
			rotate = 1'b0;
			repeat (DEBOUNCE_CYCLES + 3) @(negedge clk_sys);
			compare_value("upright", expect_in0(m_keys, joy_0, joy_1, 1'b0), game_in0);
			rotate = 1'b1;
			@(negedge clk_sys);
			compare_value("rotated", expect_in0(m_keys, joy_0, joy_1, 1'b1), game_in0);
		end
		{joy_1, rotate} = '0;

		// Random video
		ce_seen  = 1'b0;
		ce_count = 0;
		exp_vid  = '0;
		for (int i = 0; i < 200; i++) begin
			@(negedge clk_sys);
			if (ce_seen) begin
				compare_value("video", exp_vid, {vga_r, vga_g, vga_b, vga_hs, vga_vs});
			end
			{r_in, g_in, b_in, hs, vs} = 10'($urandom);
			hblank = ($urandom % 4 == 0);
			vblank = ($urandom % 6 == 0);
			ce_seen = pix_ce;
			if (pix_ce) begin
				ce_count++;
				exp_vid = {{r_in, r_in}, {g_in, g_in}, {b_in, b_in, b_in}, hs, vs};
				if (hblank || vblank) exp_vid[19:2] = '0;
			end
		end
		// One pixel enable per divider period over the whole window
		compare_value("pixel enable count", 200 / PIX_DIV, ce_count);

		// Audio windows aligned to 1024 cycles after reset
		levels = '{10'd0, 10'd1023, audio_sample_t'($urandom), audio_sample_t'($urandom)};
		while (run_cycles % 1024 != 0) @(negedge clk_sys);
		foreach (levels[k]) begin
			sample = levels[k];
			ones   = 0;
			repeat (1024) begin
				@(negedge clk_sys);
				ones += audio_l;
			end
			compare_value("audio ones", levels[k], ones);
		end
		sample = '0;

		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== arcade_io_top.sv ====
//========================================
// Arcade host glue top level
// Input path to the game bytes, output path to video and audio
//========================================
`timescale 1ns/10ps

module arcade_io_top import arcade_io_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 4,
	parameter int PIX_DIV         = 4
) (
	input  logic          clk_sys,
	input  logic          rst_n,
	// Scancode byte stream
	input  scan_code_t    scan_code,
	input  logic          scan_valid,
	output logic          scan_ready,
	// Joysticks and cabinet orientation
	input  joy_t          joy_0,
	input  joy_t          joy_1,
	input  logic          rotate,
	// Game input bytes, active low
	output game_in_t      game_in0,
	output game_in_t      game_in1,
	// Game video
	input  colour3_t      r_in,
	input  colour3_t      g_in,
	input  colour2_t      b_in,
	input  logic          hs,
	input  logic          vs,
	input  logic          hblank,
	input  logic          vblank,
	// Board video
	output logic          pix_ce,
	output vga_colour_t   vga_r,
	output vga_colour_t   vga_g,
	output vga_colour_t   vga_b,
	output logic          vga_hs,
	output logic          vga_vs,
	// Audio
	input  audio_sample_t sample,
	output logic          audio_l,
	output logic          audio_r
);

	key_vec_t keys;
	joy_t     joy_0_clean;
	joy_t     joy_1_clean;

	// ========================================
	// Input path
	// ========================================
	ps2_key_decoder ps2_key_decoder_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.scan_code  (scan_code),
		.scan_valid (scan_valid),
		.scan_ready (scan_ready),
		.keys       (keys)
	);

	joy_debounce #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) joy_debounce_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.joy_0_clean (joy_0_clean),
		.joy_1_clean (joy_1_clean)
	);

	control_mapper control_mapper_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.keys        (keys),
		.joy_0_clean (joy_0_clean),
		.joy_1_clean (joy_1_clean),
		.rotate      (rotate),
		.game_in0    (game_in0),
		.game_in1    (game_in1)
	);

	// ========================================
	// Output path
	// ========================================
	video_expander #(
		.PIX_DIV (PIX_DIV)
	) video_expander_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.r_in    (r_in),
		.g_in    (g_in),
		.b_in    (b_in),
		.hs      (hs),
		.vs      (vs),
		.hblank  (hblank),
		.vblank  (vblank),
		.pix_ce  (pix_ce),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	sigma_delta_dac sigma_delta_dac_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (sample),
		.dac_out (audio_l)
	);

	// The game sound is mono, both board channels carry the same stream
	assign audio_r = audio_l;

endmodule

// ==== sigma_delta_dac.sv ====
//========================================
// First-order sigma-delta audio DAC
//========================================
`timescale 1ns/10ps

module sigma_delta_dac import arcade_io_pkg::*; (
	input  logic          clk_sys,
	input  logic          rst_n,
	input  audio_sample_t sample,
	output logic          dac_out
);

	// Residue register plus one carry bit make the 11-bit accumulator
	logic [$bits(audio_sample_t)-1:0] acc;
	logic [$bits(audio_sample_t):0]   acc_sum;

	assign acc_sum = {1'b0, acc} + {1'b0, sample};

	// Carry density equals sample / 1024
	// From a zero residue every 1024 cycles yield exactly sample carries
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= acc_sum[$bits(audio_sample_t)-1:0];
			dac_out <= acc_sum[$bits(audio_sample_t)];
		end
	end

endmodule

// ==== video_expander.sv ====
//========================================
// Video expander for the board DAC
// Pixel enable, 3-3-2 to 6-6-6 colour, blanking and syncs
//========================================
`timescale 1ns/10ps

module video_expander import arcade_io_pkg::*; #(
	parameter int PIX_DIV = 4
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  colour3_t    r_in,
	input  colour3_t    g_in,
	input  colour2_t    b_in,
	input  logic        hs,
	input  logic        vs,
	input  logic        hblank,
	input  logic        vblank,
	output logic        pix_ce,
	output vga_colour_t vga_r,
	output vga_colour_t vga_g,
	output vga_colour_t vga_b,
	output logic        vga_hs,
	output logic        vga_vs
);

	localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             blank;

	assign blank = hblank | vblank;

	// ========================================
	// Pixel clock enable
	// ========================================
	// pix_ce rises on the last count, so one pulse every PIX_DIV cycles
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			pix_ce  <= 1'b0;
		end else begin
			pix_ce <= (div_cnt == DIV_W'(PIX_DIV - 1));
			if (div_cnt == DIV_W'(PIX_DIV - 1)) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + DIV_W'(1);
			end
		end
	end

	// ========================================
	// Colour expansion and sync alignment
	// ========================================
	// Bit replication spreads the game levels over the full 6-bit range
	// Syncs take the same register stage so they stay aligned to the colour
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (pix_ce) begin
			vga_r  <= blank ? '0 : {r_in, r_in};
			vga_g  <= blank ? '0 : {g_in, g_in};
			vga_b  <= blank ? '0 : {b_in, b_in, b_in};
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

	// Pulses stay isolated for any divider above one
	a_ce_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pix_ce |=> !pix_ce);

endmodule

// ==== control_mapper.sv ====
//========================================
// Input mapper for the game core
// Merges keys and joysticks, applies orientation, packs bytes
//========================================
`timescale 1ns/10ps

module control_mapper import arcade_io_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  key_vec_t keys,
	input  joy_t     joy_0_clean,
	input  joy_t     joy_1_clean,
	input  logic     rotate,
	output game_in_t game_in0,
	output game_in_t game_in1
);

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	// Any source may press a control
	assign src_up    = keys[KEY_UP] | joy_0_clean[JOY_UP] | joy_1_clean[JOY_UP];
	assign src_down  = keys[KEY_DOWN] | joy_0_clean[JOY_DOWN] | joy_1_clean[JOY_DOWN];
	assign src_left  = keys[KEY_LEFT] | joy_0_clean[JOY_LEFT] | joy_1_clean[JOY_LEFT];
	assign src_right = keys[KEY_RIGHT] | joy_0_clean[JOY_RIGHT] | joy_1_clean[JOY_RIGHT];
	assign m_fire    = keys[KEY_FIRE] | joy_0_clean[JOY_FIRE] | joy_1_clean[JOY_FIRE];

	// Rotated cabinet turns the stick a quarter
	// Up becomes left, down becomes right, left becomes down, right becomes up
	assign m_left  = rotate ? src_up    : src_left;
	assign m_right = rotate ? src_down  : src_right;
	assign m_down  = rotate ? src_left  : src_down;
	assign m_up    = rotate ? src_right : src_up;

	// The core reads its inputs active low
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			game_in0 <= '1;
			game_in1 <= '1;
		end else begin
			game_in0 <= ~{2'b00, keys[KEY_COIN], m_fire, m_down, m_right, m_left, m_up};
			game_in1 <= ~{1'b0, keys[KEY_START2], keys[KEY_START1], 5'b00000};
		end
	end

	// The two spare lines of the first byte read as released at all times
	a_in0_spare: assert property (@(posedge clk_sys) disable iff (!rst_n)
		game_in0[7:6] == 2'b11);

endmodule

// ==== joy_debounce.sv ====
//========================================
// Joystick debouncer for two ports
// One run-length counter per used bit
//========================================
`timescale 1ns/10ps

module joy_debounce import arcade_io_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 4
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  joy_t joy_0,
	input  joy_t joy_1,
	output joy_t joy_0_clean,
	output joy_t joy_1_clean
);

	// Five used bits per port, both ports side by side
	localparam int JOY_USED = 5;
	localparam int NUM_BITS = 2 * JOY_USED;
	localparam int CNT_W    = $clog2(DEBOUNCE_CYCLES + 1);

	logic [NUM_BITS-1:0] raw;
	logic [NUM_BITS-1:0] raw_q;
	logic [NUM_BITS-1:0] clean;
	logic [CNT_W-1:0]    run_len [NUM_BITS];
	logic [CNT_W-1:0]    run_nxt [NUM_BITS];

	assign raw = {joy_1[JOY_USED-1:0], joy_0[JOY_USED-1:0]};

	// Length of the run of equal samples including this cycle
	// It saturates at DEBOUNCE_CYCLES and drops back to one on any change
	always_comb begin
		for (int i = 0; i < NUM_BITS; i++) begin
			if (raw[i] != raw_q[i]) begin
				run_nxt[i] = CNT_W'(1);
			end else if (run_len[i] == CNT_W'(DEBOUNCE_CYCLES)) begin
				run_nxt[i] = run_len[i];
			end else begin
				run_nxt[i] = run_len[i] + CNT_W'(1);
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			raw_q <= '0;
			clean <= '0;
			for (int i = 0; i < NUM_BITS; i++) begin
				run_len[i] <= '0;
			end
		end else begin
			raw_q <= raw;
			for (int i = 0; i < NUM_BITS; i++) begin
				run_len[i] <= run_nxt[i];
				// The clean bit follows once the run is long enough
				if (run_nxt[i] == CNT_W'(DEBOUNCE_CYCLES)) begin
					clean[i] <= raw[i];
				end
			end
		end
	end

	assign joy_0_clean = {{($bits(joy_t) - JOY_USED){1'b0}}, clean[JOY_USED-1:0]};
	assign joy_1_clean = {{($bits(joy_t) - JOY_USED){1'b0}}, clean[NUM_BITS-1:JOY_USED]};

endmodule

// ==== ps2_key_decoder.sv ====
//========================================
// PS/2 scancode decoder for the arcade keys
// Follows release and extended prefixes and holds the key state
//========================================
`timescale 1ns/10ps

module ps2_key_decoder import arcade_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  scan_code_t scan_code,
	input  logic       scan_valid,
	output logic       scan_ready,
	output key_vec_t   keys
);

	// Prefix tracker, each prefix arms a flag for the next byte only
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXT,
		ST_REL,
		ST_EXT_REL
	} prefix_state_t;

	prefix_state_t state;
	logic          xfer;
	logic          in_ext;
	logic          in_rel;
	logic          code_hit;
	logic          code_ext;
	key_idx_t      code_idx;

	assign xfer   = scan_valid && scan_ready;
	assign in_ext = (state == ST_EXT) || (state == ST_EXT_REL);
	assign in_rel = (state == ST_REL) || (state == ST_EXT_REL);

	// Make code lookup
	// code_ext marks codes that only count behind the extended prefix
	always_comb begin
		code_hit = 1'b1;
		code_ext = 1'b0;
		code_idx = KEY_FIRE;
		case (scan_code)
			SC_SPACE: code_idx = KEY_FIRE;
			SC_1:     code_idx = KEY_START1;
			SC_2:     code_idx = KEY_START2;
			SC_5:     code_idx = KEY_COIN;
			SC_RIGHT: begin
				code_idx = KEY_RIGHT;
				code_ext = 1'b1;
			end
			SC_LEFT: begin
				code_idx = KEY_LEFT;
				code_ext = 1'b1;
			end
			SC_UP: begin
				code_idx = KEY_UP;
				code_ext = 1'b1;
			end
			SC_DOWN: begin
				code_idx = KEY_DOWN;
				code_ext = 1'b1;
			end
			default: code_hit = 1'b0;
		endcase
	end

	// The decoder takes a byte every cycle once out of reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			scan_ready <= 1'b0;
			state      <= ST_IDLE;
			keys       <= '0;
		end else begin
			scan_ready <= 1'b1;
			if (xfer) begin
				if (scan_code == KEY_RELEASE_PREFIX) begin
					state <= in_ext ? ST_EXT_REL : ST_REL;
				end else if (scan_code == KEY_EXTENDED_PREFIX) begin
					state <= in_rel ? ST_EXT_REL : ST_EXT;
				end else begin
					// Any other byte ends the prefix sequence
					state <= ST_IDLE;
					if (code_hit && (code_ext == in_ext)) begin
						keys[code_idx] <= !in_rel;
					end
				end
			end
		end
	end

	// A byte offered while the decoder is not ready has to stay put
	a_scan_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(scan_valid && !scan_ready) |=> (scan_valid && $stable(scan_code)));

endmodule

// ==== arcade_io_pkg.sv ====
//========================================
// Shared definitions for the arcade host glue
// Width typedefs, PS/2 scancodes, key and joystick bit order
//========================================

package arcade_io_pkg;

	// ========================================
	// Width typedefs
	// ========================================
	typedef logic [7:0] scan_code_t;
	typedef logic [7:0] key_vec_t;
	typedef logic [7:0] joy_t;
	typedef logic [7:0] game_in_t;
	typedef logic [2:0] colour3_t;
	typedef logic [1:0] colour2_t;
	typedef logic [5:0] vga_colour_t;
	typedef logic [9:0] audio_sample_t;
	typedef logic [2:0] key_idx_t;

	// ========================================
	// Key bit order inside key_vec_t
	// ========================================
	localparam key_idx_t KEY_FIRE   = 3'd0;
	localparam key_idx_t KEY_START1 = 3'd1;
	localparam key_idx_t KEY_START2 = 3'd2;
	localparam key_idx_t KEY_COIN   = 3'd3;
	localparam key_idx_t KEY_RIGHT  = 3'd4;
	localparam key_idx_t KEY_LEFT   = 3'd5;
	localparam key_idx_t KEY_UP     = 3'd6;
	localparam key_idx_t KEY_DOWN   = 3'd7;

	// Joystick bit order inside joy_t, bits 5 to 7 carry nothing
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// ========================================
	// PS/2 set 2 scancodes
	// ========================================
	localparam scan_code_t KEY_RELEASE_PREFIX  = 8'hF0;
	localparam scan_code_t KEY_EXTENDED_PREFIX = 8'hE0;
	// Plain make codes
	localparam scan_code_t SC_SPACE = 8'h29;
	localparam scan_code_t SC_1     = 8'h16;
	localparam scan_code_t SC_2     = 8'h1E;
	localparam scan_code_t SC_5     = 8'h2E;
	// Arrow make codes, only valid after KEY_EXTENDED_PREFIX
	localparam scan_code_t SC_RIGHT = 8'h74;
	localparam scan_code_t SC_LEFT  = 8'h6B;
	localparam scan_code_t SC_UP    = 8'h75;
	localparam scan_code_t SC_DOWN  = 8'h72;

endpackage
